/* list.f */
+incdir+hdl
hdl/lsu_wb_pkg.sv
hdl/ex_capture.sv
hdl/mem_access.sv
hdl/data_ram.sv
hdl/write_back.sv
hdl/reg_file.sv
hdl/lsu_wb_top.sv
verif/lsu_wb_props.sv
verif/lsu_wb_tb.sv

/* verif/lsu_wb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_wb_params.svh"

module lsu_wb_tb;
    import lsu_wb_pkg::*;

    localparam int NUM_RANDOM      = 200;
    localparam int NUM_DIRECTED    = 48; // upper bound on the directed sequence.
    localparam int SETUP_CYCLES    = (1 << `RAM_DEPTH_LOG2) + 4 * 32 * 2 + 64;
    localparam int WATCHDOG_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 16 + SETUP_CYCLES;

    logic     clk;
    logic     reset;
    logic     req;
    logic     ack;
    addr_t    pc;
    inst_t    inst;
    data_t    alu_result;
    data_t    store_data;
    logic     rw_en_in;
    reg_idx_t rf_raddr;
    data_t    rf_rdata;
    addr_t    debug_wb_pc;
    logic     debug_wb_rf_wen;
    reg_idx_t debug_wb_rf_wnum;
    data_t    debug_wb_rf_wdata;

    data_t       model_mem [1 << `RAM_DEPTH_LOG2];
    data_t       model_regs [32];
    addr_t       exp_pc [$];
    reg_idx_t    exp_rd [$];
    data_t       exp_data [$];
    string       exp_name [$];
    string       test_name;
    string       trace_name;
    logic [31:0] lcg_state = 32'h9bd57c31;
    addr_t       next_pc = 32'h1c00_0000;
    int          errors = 0;
    int          checks = 0;
    int          traces_seen = 0;
    int          traces_expected = 0;

    lsu_wb_top UUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        return int'((lcg_next() >> 8) % n);
    endfunction

    function automatic inst_t mem_inst(lsu_op_e op, reg_idx_t rd);
        return {`LSU_MAJOR, 4'(op), 17'b0, rd};
    endfunction

    function automatic inst_t alu_inst(reg_idx_t rd);
        return {6'b000100, 21'(lcg_next()), rd}; // any major opcode but the memory one.
    endfunction

    function automatic logic is_store_inst(inst_t i);
        lsu_op_e op;
        op = lsu_op_e'(i[25:22]);
        return (i[31:26] == `LSU_MAJOR) && (op == LSU_ST_B || op == LSU_ST_H || op == LSU_ST_W);
    endfunction

    // register value an instruction should write, read from the memory model.
    function automatic data_t expected_result(inst_t i, data_t addr);
        data_t       word;
        logic [7:0]  b;
        logic [15:0] h;
        int          ext;
        word = model_mem[addr[`RAM_DEPTH_LOG2 + 1 : 2]];
        b    = word[8 * addr[1:0] +: 8];
        h    = word[16 * addr[1] +: 16];
        if (i[31:26] != `LSU_MAJOR) return addr;
        case (lsu_op_e'(i[25:22]))
            LSU_LD_B:  ext = $signed(b);
            LSU_LD_H:  ext = $signed(h);
            LSU_LD_BU: ext = b;
            LSU_LD_HU: ext = h;
            LSU_LD_W:  ext = word;
            default:   ext = addr;
        endcase
        return data_t'(ext);
    endfunction

    task automatic model_store(inst_t i, data_t addr, data_t sd);
        int    idx;
        data_t word;
        idx  = addr[`RAM_DEPTH_LOG2 + 1 : 2];
        word = model_mem[idx];
        case (lsu_op_e'(i[25:22]))
            LSU_ST_B: word[8 * addr[1:0] +: 8] = sd[7:0];
            LSU_ST_H: word[16 * addr[1] +: 16] = sd[15:0]; // half lanes picked by bit 1.
            default:  word = sd;
        endcase
        model_mem[idx] = word;
    endtask

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // one instruction through the four-phase input handshake.
    task automatic issue(inst_t i, data_t alu, data_t sd, logic rw);
        data_t v;
        v = expected_result(i, alu);
        if (rw && !is_store_inst(i)) begin
            exp_pc.push_back(next_pc);
            exp_rd.push_back(i[4:0]);
            exp_data.push_back(v);
            exp_name.push_back(test_name);
            traces_expected++;
            if (i[4:0] != 0) model_regs[i[4:0]] = v;
        end
        if (is_store_inst(i)) model_store(i, alu, sd);
        @(posedge clk);
        req        <= 1'b1;
        pc         <= next_pc;
        inst       <= i;
        alu_result <= alu;
        store_data <= sd;
        rw_en_in   <= rw;
        do @(posedge clk); while (!ack);
        req <= 1'b0;
        do @(posedge clk); while (ack);
        next_pc = next_pc + 4;
    endtask

    task automatic issue_random();
        data_t    addr;
        reg_idx_t rd;
        logic     rw;
        lsu_op_e  op;
        addr = data_t'(rand_below(16) * 4); // small window so loads hit earlier stores.
        rd   = reg_idx_t'(rand_below(32));
        rw   = (rand_below(8) != 0);
        case (rand_below(8))
            0, 1: issue(alu_inst(rd), lcg_next(), lcg_next(), rw);
            2: issue(mem_inst(LSU_ST_W, rd), addr, lcg_next(), rw);
            3: issue(mem_inst(LSU_ST_B, rd), addr + rand_below(4), lcg_next(), rw);
            4: issue(mem_inst(LSU_ST_H, rd), addr + rand_below(4), lcg_next(), rw);
            5: begin
                op = LSU_LD_B;
                if (rand_below(2) != 0) op = LSU_LD_BU;
                issue(mem_inst(op, rd), addr + rand_below(4), '0, rw);
            end
            6: begin
                op = LSU_LD_H;
                if (rand_below(2) != 0) op = LSU_LD_HU;
                issue(mem_inst(op, rd), addr + 2 * rand_below(2), '0, rw);
            end
            default: issue(mem_inst(LSU_LD_W, rd), addr, '0, rw);
        endcase
    endtask

    task automatic scan_regs(string name);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            rf_raddr <= reg_idx_t'(r);
            @(posedge clk);
            check($sformatf("%s r%0d", name, r), model_regs[r], rf_rdata);
        end
        rf_raddr <= '0; // keep r0 on the read port during traffic.
    endtask

    // every trace pulse is matched against the oldest expected write.
    always @(posedge clk) begin
        if (!reset && debug_wb_rf_wen) begin
            traces_seen++;
            if (exp_pc.size() == 0) begin
                errors++;
                $display("unexpected register write to r%0d at pc %h",
                         debug_wb_rf_wnum, debug_wb_pc);
            end else begin
                trace_name = exp_name.pop_front();
                check({trace_name, " pc"}, exp_pc.pop_front(), debug_wb_pc);
                check({trace_name, " rd"}, exp_rd.pop_front(), debug_wb_rf_wnum);
                check({trace_name, " data"}, exp_data.pop_front(), debug_wb_rf_wdata);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles with %0d results still pending",
                 WATCHDOG_CYCLES, exp_pc.size());
        $display("Test failures found");
        $finish;
    end

    initial begin
        data_t addr;
        data_t d;
        int    off;
        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        pc         = '0;
        inst       = '0;
        alu_result = '0;
        store_data = '0;
        rw_en_in   = 1'b0;
        rf_raddr   = '0;
        foreach (model_mem[k]) model_mem[k] = '0;
        foreach (model_regs[k]) model_regs[k] = '0;

        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check("reset ack", 0, ack);
        check("reset trace wen", 0, debug_wb_rf_wen);
        scan_regs("reset regs");
        repeat ((1 << `RAM_DEPTH_LOG2) + 4) @(posedge clk); // RAM clear sweep.

        test_name = "alu";
        for (int n = 0; n < 8; n++) begin
            issue(alu_inst(reg_idx_t'(n + 1)), lcg_next(), lcg_next(), n % 4 != 3);
        end

        test_name = "store word load word";
        for (int n = 0; n < 4; n++) begin
            addr = data_t'(rand_below(16) * 4);
            issue(mem_inst(LSU_ST_W, 5'd9), addr, lcg_next(), 1'b1);
            issue(mem_inst(LSU_LD_W, reg_idx_t'(10 + n)), addr, '0, 1'b1);
        end

        test_name = "byte and half merge";
        addr = 32'h0000_0040;
        issue(mem_inst(LSU_ST_W, 5'd0), addr, 32'h1234_5678, 1'b0);
        for (off = 0; off < 4; off++) begin
            d    = lcg_next();
            d[7] = off[0]; // both signs of byte.
            issue(mem_inst(LSU_ST_B, 5'd1), addr + off, d, 1'b1);
            issue(mem_inst(LSU_LD_B, 5'd2), addr + off, '0, 1'b1);
            issue(mem_inst(LSU_LD_BU, 5'd3), addr + off, '0, 1'b1);
        end
        for (off = 0; off < 4; off += 2) begin
            d     = lcg_next();
            d[15] = !off[1];
            issue(mem_inst(LSU_ST_H, 5'd1), addr + off, d, 1'b1);
            issue(mem_inst(LSU_LD_H, 5'd5), addr + off, '0, 1'b1);
            issue(mem_inst(LSU_LD_HU, 5'd6), addr + off, '0, 1'b1);
        end
        issue(mem_inst(LSU_LD_W, 5'd4), addr, '0, 1'b1);

        test_name = "r0 write";
        issue(alu_inst(5'd0), 32'hdead_beef, '0, 1'b1);
        issue(mem_inst(LSU_LD_W, 5'd0), addr, '0, 1'b1);

        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue_random();
            repeat (rand_below(6)) @(posedge clk);
        end

        while (exp_pc.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);
        check("trace count", traces_expected, traces_seen);
        scan_regs("final regs");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/lsu_wb_props.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_wb_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  req,
    input logic                  ack,
    input logic                  cap_valid,
    input logic                  mem_valid,
    input logic                  debug_wb_rf_wen,
    input lsu_wb_pkg::reg_idx_t  debug_wb_rf_wnum,
    input lsu_wb_pkg::reg_idx_t  rf_raddr,
    input lsu_wb_pkg::data_t     rf_rdata
);

    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req) && cap_valid)
        else $error("ack rose without a request being captured");

    // source keeps req up until it sees ack.
    req_held: assert property (@(posedge clk) disable iff (reset)
        req && !ack |=> req)
        else $error("req dropped before ack");

    req_waits_for_ack_low: assert property (@(posedge clk) disable iff (reset)
        ack && !req |=> !req)
        else $error("new req raised while ack still high");

    // a request seen while idle is captured, then reaches the memory stage.
    req_to_mem: assert property (@(posedge clk) disable iff (reset)
        req && !ack |=> cap_valid ##1 (mem_valid && !cap_valid))
        else $error("accepted request did not reach the memory stage two cycles later");

    r0_stays_zero: assert property (@(posedge clk) disable iff (reset)
        debug_wb_rf_wen && (debug_wb_rf_wnum == '0) |=> (rf_raddr != '0) || (rf_rdata == '0))
        else $error("r0 reads nonzero after a write to it");

endmodule

bind lsu_wb_top lsu_wb_props u_lsu_wb_props (
    .clk(clk), .reset(reset), .req(req), .ack(ack),
    .cap_valid(cap_valid), .mem_valid(mem_valid),
    .debug_wb_rf_wen(debug_wb_rf_wen), .debug_wb_rf_wnum(debug_wb_rf_wnum),
    .rf_raddr(rf_raddr), .rf_rdata(rf_rdata)
);

`default_nettype wire

/* hdl/lsu_wb_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_wb_params.svh"

module lsu_wb_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  lsu_wb_pkg::addr_t     pc,
    input  lsu_wb_pkg::inst_t     inst,
    input  lsu_wb_pkg::data_t     alu_result,
    input  lsu_wb_pkg::data_t     store_data,
    input  logic                  rw_en_in,
    input  lsu_wb_pkg::reg_idx_t  rf_raddr,
    output lsu_wb_pkg::data_t     rf_rdata,
    output lsu_wb_pkg::addr_t     debug_wb_pc,
    output logic                  debug_wb_rf_wen,
    output lsu_wb_pkg::reg_idx_t  debug_wb_rf_wnum,
    output lsu_wb_pkg::data_t     debug_wb_rf_wdata
);
    import lsu_wb_pkg::*;

    logic                           cap_valid;
    addr_t                          cap_pc;
    addr_t                          cap_addr;
    inst_t                          cap_inst;
    data_t                          cap_store_data;
    logic                           cap_rw_en;
    logic                           ram_en;
    logic                           ram_we;
    strb_t                          ram_strb;
    logic [`RAM_DEPTH_LOG2 - 1 : 0] ram_addr;
    data_t                          ram_wdata;
    data_t                          ram_rd_data;
    logic                           mem_valid;
    logic                           mem_is_load;
    logic                           mem_rw_en;
    addr_t                          mem_pc;
    lsu_op_e                        mem_lsu_op;
    logic [1 : 0]                   mem_byte_off;
    reg_idx_t                       mem_rd;
    data_t                          mem_result;
    logic                           rf_we;
    reg_idx_t                       rf_waddr;
    data_t                          rf_wdata;

    ex_capture u_ex_capture (
        .clk(clk), .reset(reset), .req(req), .ack(ack),
        .pc(pc), .inst(inst), .alu_result(alu_result), .store_data(store_data),
        .rw_en_in(rw_en_in), .cap_valid(cap_valid), .cap_pc(cap_pc),
        .cap_addr(cap_addr), .cap_inst(cap_inst), .cap_store_data(cap_store_data),
        .cap_rw_en(cap_rw_en)
    );

    mem_access u_mem_access (
        .clk(clk), .reset(reset), .cap_valid(cap_valid), .cap_pc(cap_pc),
        .cap_inst(cap_inst), .cap_addr(cap_addr), .cap_store_data(cap_store_data),
        .cap_rw_en(cap_rw_en), .ram_en(ram_en), .ram_we(ram_we), .ram_strb(ram_strb),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .mem_valid(mem_valid),
        .mem_is_load(mem_is_load), .mem_rw_en(mem_rw_en), .mem_pc(mem_pc),
        .mem_lsu_op(mem_lsu_op), .mem_byte_off(mem_byte_off), .mem_rd(mem_rd),
        .mem_result(mem_result)
    );

    data_ram #(.DEPTH_LOG2(`RAM_DEPTH_LOG2)) u_data_ram (
        .clk(clk), .reset(reset), .ram_en(ram_en), .ram_we(ram_we),
        .ram_strb(ram_strb), .ram_addr(ram_addr), .ram_wdata(ram_wdata),
        .ram_rd_data(ram_rd_data)
    );

    write_back u_write_back (
        .mem_valid(mem_valid), .mem_is_load(mem_is_load), .mem_rw_en(mem_rw_en),
        .mem_pc(mem_pc), .mem_lsu_op(mem_lsu_op), .mem_byte_off(mem_byte_off),
        .mem_rd(mem_rd), .mem_result(mem_result), .ram_rd_data(ram_rd_data),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    reg_file u_reg_file (
        .clk(clk), .reset(reset), .rf_we(rf_we), .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata), .rf_raddr(rf_raddr), .rf_rdata(rf_rdata)
    );

endmodule

`default_nettype wire

/* hdl/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_wb_params.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rf_we,
    input  lsu_wb_pkg::reg_idx_t  rf_waddr,
    input  lsu_wb_pkg::data_t     rf_wdata,
    input  lsu_wb_pkg::reg_idx_t  rf_raddr,
    output lsu_wb_pkg::data_t     rf_rdata
);
    import lsu_wb_pkg::*;

    localparam int NUM_REGS = 1 << `REG_WIDTH;

    data_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we && (rf_waddr != '0)) begin
            regs[rf_waddr] <= rf_wdata; // r0 stays zero.
        end
    end

    assign rf_rdata = regs[rf_raddr];

endmodule

`default_nettype wire

/* hdl/write_back.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back (
    input  logic                  mem_valid,
    input  logic                  mem_is_load,
    input  logic                  mem_rw_en,
    input  lsu_wb_pkg::addr_t     mem_pc,
    input  lsu_wb_pkg::lsu_op_e   mem_lsu_op,
    input  logic [1 : 0]          mem_byte_off,
    input  lsu_wb_pkg::reg_idx_t  mem_rd,
    input  lsu_wb_pkg::data_t     mem_result,
    input  lsu_wb_pkg::data_t     ram_rd_data,
    output logic                  rf_we,
    output lsu_wb_pkg::reg_idx_t  rf_waddr,
    output lsu_wb_pkg::data_t     rf_wdata,
    output lsu_wb_pkg::addr_t     debug_wb_pc,
    output logic                  debug_wb_rf_wen,
    output lsu_wb_pkg::reg_idx_t  debug_wb_rf_wnum,
    output lsu_wb_pkg::data_t     debug_wb_rf_wdata
);
    import lsu_wb_pkg::*;

    data_t shifted;
    data_t load_val;

    // bring the addressed byte down to lane 0.
    assign shifted = ram_rd_data >> {mem_byte_off, 3'b000};

    always_comb begin
        case (mem_lsu_op)
            LSU_LD_B:  load_val = {{24{shifted[7]}}, shifted[7:0]};
            LSU_LD_H:  load_val = {{16{shifted[15]}}, shifted[15:0]};
            LSU_LD_BU: load_val = {24'b0, shifted[7:0]};
            LSU_LD_HU: load_val = {16'b0, shifted[15:0]};
            default:   load_val = shifted; // LD.W.
        endcase
    end

    assign rf_we    = mem_valid && mem_rw_en;
    assign rf_waddr = mem_rd;
    assign rf_wdata = mem_is_load ? load_val : mem_result;

    // trace mirrors the register-file write.
    assign debug_wb_pc       = mem_pc;
    assign debug_wb_rf_wen   = rf_we;
    assign debug_wb_rf_wnum  = rf_waddr;
    assign debug_wb_rf_wdata = rf_wdata;

endmodule

`default_nettype wire

/* hdl/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_wb_params.svh"

module data_ram #(
    parameter int DEPTH_LOG2 = `RAM_DEPTH_LOG2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       ram_en,
    input  logic                       ram_we,
    input  lsu_wb_pkg::strb_t          ram_strb,
    input  logic [DEPTH_LOG2 - 1 : 0]  ram_addr,
    input  lsu_wb_pkg::data_t          ram_wdata,
    output lsu_wb_pkg::data_t          ram_rd_data
);
    import lsu_wb_pkg::*;

    data_t                     mem [1 << DEPTH_LOG2];
    logic                      clr_busy;
    logic [DEPTH_LOG2 - 1 : 0] clr_addr;

    // after reset, walk every word and zero it.
    always_ff @(posedge clk) begin
        if (reset) begin
            clr_busy <= 1'b1;
            clr_addr <= '0;
        end else if (clr_busy) begin
            clr_addr <= clr_addr + 1'b1;
            if (&clr_addr) clr_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset && clr_busy) begin
            mem[clr_addr] <= '0;
        end else if (ram_en && ram_we) begin
            for (int i = 0; i < $bits(strb_t); i++) begin
                if (ram_strb[i]) mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ram_en && !ram_we) ram_rd_data <= mem[ram_addr]; // one-cycle read.
    end

endmodule

`default_nettype wire

/* hdl/mem_access.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lsu_wb_params.svh"

module mem_access (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cap_valid,
    input  lsu_wb_pkg::addr_t               cap_pc,
    input  lsu_wb_pkg::inst_t               cap_inst,
    input  lsu_wb_pkg::addr_t               cap_addr,
    input  lsu_wb_pkg::data_t               cap_store_data,
    input  logic                            cap_rw_en,
    output logic                            ram_en,
    output logic                            ram_we,
    output lsu_wb_pkg::strb_t               ram_strb,
    output logic [`RAM_DEPTH_LOG2 - 1 : 0]  ram_addr,
    output lsu_wb_pkg::data_t               ram_wdata,
    output logic                            mem_valid,
    output logic                            mem_is_load,
    output logic                            mem_rw_en,
    output lsu_wb_pkg::addr_t               mem_pc,
    output lsu_wb_pkg::lsu_op_e             mem_lsu_op,
    output logic [1 : 0]                    mem_byte_off,
    output lsu_wb_pkg::reg_idx_t            mem_rd,
    output lsu_wb_pkg::data_t               mem_result
);
    import lsu_wb_pkg::*;

    lsu_op_e op;
    logic    is_mem;
    logic    is_load;
    logic    is_store;
    strb_t   lane_strb;

    assign op     = lsu_op_e'(cap_inst[`OPC_SUB_HI : `OPC_SUB_LO]);
    assign is_mem = (cap_inst[`OPC_MAJOR_HI : `OPC_MAJOR_LO] == `LSU_MAJOR);

    always_comb begin
        is_load  = 1'b0;
        is_store = 1'b0;
        if (is_mem) begin
            case (op)
                LSU_LD_B, LSU_LD_H, LSU_LD_W,
                LSU_LD_BU, LSU_LD_HU:         is_load  = 1'b1;
                LSU_ST_B, LSU_ST_H, LSU_ST_W: is_store = 1'b1;
                default:                      ; // not a memory op.
            endcase
        end
    end

    // replicate the store data so every lane sees it, strobes pick the lanes.
    always_comb begin
        case (op)
            LSU_ST_B: begin
                ram_wdata = {4{cap_store_data[7:0]}};
                lane_strb = strb_t'(4'b0001 << cap_addr[1:0]);
            end
            LSU_ST_H: begin
                ram_wdata = {2{cap_store_data[15:0]}};
                lane_strb = cap_addr[1] ? strb_t'(4'b1100) : strb_t'(4'b0011);
            end
            default: begin
                ram_wdata = cap_store_data;
                lane_strb = strb_t'(4'b1111);
            end
        endcase
    end

    assign ram_en   = cap_valid && (is_load || is_store);
    assign ram_we   = cap_valid && is_store;
    assign ram_strb = ram_we ? lane_strb : '0;
    assign ram_addr = cap_addr[`RAM_DEPTH_LOG2 + 1 : 2]; // word index.

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid <= 1'b0;
            mem_rw_en <= 1'b0;
        end else begin
            mem_valid <= cap_valid;
            mem_rw_en <= cap_valid && cap_rw_en && !is_store; // stores never write rd.
        end
    end

    always_ff @(posedge clk) begin
        if (cap_valid) begin
            mem_pc       <= cap_pc;
            mem_lsu_op   <= op;
            mem_is_load  <= is_load;
            mem_byte_off <= cap_addr[1:0];
            mem_rd       <= cap_inst[`INST_RD_HI : `INST_RD_LO];
            mem_result   <= cap_addr;
        end
    end

endmodule

`default_nettype wire

/* hdl/ex_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module ex_capture (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    output logic               ack,
    input  lsu_wb_pkg::addr_t  pc,
    input  lsu_wb_pkg::inst_t  inst,
    input  lsu_wb_pkg::data_t  alu_result,
    input  lsu_wb_pkg::data_t  store_data,
    input  logic               rw_en_in,
    output logic               cap_valid,
    output lsu_wb_pkg::addr_t  cap_pc,
    output lsu_wb_pkg::addr_t  cap_addr,
    output lsu_wb_pkg::inst_t  cap_inst,
    output lsu_wb_pkg::data_t  cap_store_data,
    output logic               cap_rw_en
);
    import lsu_wb_pkg::*;

    hs_state_e state;
    logic      accept;

    assign accept = (state == HS_IDLE) && req; // new bundle on the bus.
    assign ack    = (state == HS_ACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= HS_IDLE;
            cap_valid <= 1'b0;
        end else begin
            cap_valid <= accept; // one pulse per handshake.
            case (state)
                HS_IDLE: if (req) state <= HS_ACK;
                HS_ACK:  if (!req) state <= HS_IDLE; // drop ack once req is gone.
                default: state <= HS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cap_pc         <= pc;
            cap_inst       <= inst;
            cap_addr       <= alu_result;
            cap_store_data <= store_data;
            cap_rw_en      <= rw_en_in;
        end
    end

endmodule

`default_nettype wire

/* hdl/lsu_wb_pkg.sv */
`default_nettype none

`include "lsu_wb_params.svh"

package lsu_wb_pkg;

    typedef logic [`DATA_WIDTH - 1 : 0]     data_t;
    typedef logic [`ADDR_WIDTH - 1 : 0]     addr_t;
    typedef logic [`REG_WIDTH - 1 : 0]      reg_idx_t;
    typedef logic [31 : 0]                  inst_t;
    typedef logic [`DATA_WIDTH / 8 - 1 : 0] strb_t;

    // memory sub-opcode, inst[25:22].
    typedef enum logic [3 : 0] {
        LSU_LD_B  = 4'b0000,
        LSU_LD_H  = 4'b0001,
        LSU_LD_W  = 4'b0010,
        LSU_ST_B  = 4'b0100,
        LSU_ST_H  = 4'b0101,
        LSU_ST_W  = 4'b0110,
        LSU_LD_BU = 4'b1000,
        LSU_LD_HU = 4'b1001
    } lsu_op_e;

    typedef enum logic {
        HS_IDLE,
        HS_ACK
    } hs_state_e;

endpackage

`default_nettype wire

/* hdl/lsu_wb_params.svh */
`ifndef LSU_WB_PARAMS_SVH
`define LSU_WB_PARAMS_SVH

// datapath widths.
`define DATA_WIDTH      32
`define ADDR_WIDTH      32
`define REG_WIDTH       5

// word-address bits of the data RAM.
`define RAM_DEPTH_LOG2  8

// instruction fields used by the memory stage.
`define OPC_MAJOR_HI    31
`define OPC_MAJOR_LO    26
`define OPC_SUB_HI      25
`define OPC_SUB_LO      22
`define INST_RD_HI      4
`define INST_RD_LO      0

// major opcode shared by all loads and stores.
`define LSU_MAJOR       6'b001010

`endif
